// ==== hdl/stripe_settings.svh ====
`ifndef STRIPE_SETTINGS_SVH
`define STRIPE_SETTINGS_SVH

// number of banks the data is striped across, must be a power of two
`define STRIPE_NUM_BANKS 2

// width of a word address, addresses count words and not bytes
`define STRIPE_ADDR_WIDTH 20

// width of one data word
`define STRIPE_DATA_WIDTH 16

// width of the 0-based beat count, so 0 means a single beat
`define STRIPE_LENW_WIDTH 8

`endif

// ==== hdl/axi_lite_pkg.sv ====
package axi_lite_pkg;

  // read response codes as they appear on rresp
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_t;

endpackage

// ==== hdl/stripe_pkg.sv ====
`include "stripe_settings.svh"

package stripe_pkg;

  // width of each status counter and of the status read port
  localparam int STAT_WIDTH = 16;

  // command as the scheduler holds it for the length of one burst
  typedef struct packed {
    logic [`STRIPE_ADDR_WIDTH-1:0] addr;
    logic [`STRIPE_LENW_WIDTH-1:0] lenw;
  } stripe_cmd_t;

  // which counter shows up on stat_data
  typedef enum logic {
    STAT_BURSTS = 1'b0,
    STAT_ERRORS = 1'b1
  } stat_sel_t;

endpackage

// ==== hdl/stripe_read_if.sv ====
`include "stripe_settings.svh"

// one sub-burst read channel between the scheduler and a bank reader
interface stripe_read_if;
  import axi_lite_pkg::*;

  logic [`STRIPE_ADDR_WIDTH-1:0] araddr;
  logic [`STRIPE_LENW_WIDTH-1:0] arlenw;
  logic                          arvalid;
  logic                          arready;
  logic [`STRIPE_DATA_WIDTH-1:0] rdata;
  axi_resp_t                     rresp;
  logic                          rvalid;
  logic                          rlast;
  logic                          rready;

  modport sched(
    output araddr,
    output arlenw,
    output arvalid,
    output rready,
    input  arready,
    input  rdata,
    input  rresp,
    input  rvalid,
    input  rlast
  );

  modport reader(
    input  araddr,
    input  arlenw,
    input  arvalid,
    input  rready,
    output arready,
    output rdata,
    output rresp,
    output rvalid,
    output rlast
  );

endinterface

// ==== hdl/bank_burst_reader.sv ====
`include "stripe_settings.svh"

module bank_burst_reader (
  input  logic                          axi_clk,
  input  logic                          axi_resetn,

  stripe_read_if.reader                 rd,

  output logic [`STRIPE_ADDR_WIDTH-1:0] bank_araddr,
  output logic                          bank_arvalid,
  input  logic                          bank_arready,
  input  logic [`STRIPE_DATA_WIDTH-1:0] bank_rdata,
  input  logic [                   1:0] bank_rresp,
  input  logic                          bank_rvalid,
  output logic                          bank_rready
);
  import axi_lite_pkg::*;

  localparam int ADDR_W = `STRIPE_ADDR_WIDTH;
  localparam int LENW_W = `STRIPE_LENW_WIDTH;

  logic                          busy;
  logic [LENW_W:0]               reads_left;
  logic [ADDR_W-1:0]             next_addr;
  logic                          r_pend;
  logic                          pend_last;
  logic                          buf_valid;
  logic [`STRIPE_DATA_WIDTH-1:0] buf_data;
  axi_resp_t                     buf_resp;
  logic                          buf_last;
  logic                          accept;
  logic                          drain;

  assign accept = rd.arvalid && rd.arready;
  assign drain  = rd.rvalid && rd.rready;

  assign rd.arready = !busy;
  assign rd.rvalid  = buf_valid;
  assign rd.rdata   = buf_data;
  assign rd.rresp   = buf_resp;
  assign rd.rlast   = buf_last;

  assign bank_araddr = next_addr;

  // a response may land in the buffer in the same cycle the old word leaves
  assign bank_rready = r_pend && (!buf_valid || drain);

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      busy         <= 1'b0;
      bank_arvalid <= 1'b0;
      r_pend       <= 1'b0;
      buf_valid    <= 1'b0;
    end else begin
      if (accept) begin
        busy       <= 1'b1;
        next_addr  <= rd.araddr;
        reads_left <= {1'b0, rd.arlenw} + 1'b1;
      end

      // one read on the bank bus at a time, the buffer covers the stall
      if (busy && !bank_arvalid && !r_pend && reads_left != '0) begin
        bank_arvalid <= 1'b1;
      end

      if (bank_arvalid && bank_arready) begin
        bank_arvalid <= 1'b0;
        r_pend       <= 1'b1;
        pend_last    <= (reads_left == 1);
        next_addr    <= next_addr + ADDR_W'(`STRIPE_NUM_BANKS);
        reads_left   <= reads_left - 1'b1;
      end

      if (bank_rvalid && bank_rready) begin
        r_pend    <= 1'b0;
        buf_valid <= 1'b1;
        buf_data  <= bank_rdata;
        buf_resp  <= axi_resp_t'(bank_rresp);
        buf_last  <= pend_last;
      end else if (drain) begin
        buf_valid <= 1'b0;
      end

      if (drain && buf_last) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/stripe_scheduler.sv ====
`include "stripe_settings.svh"

module stripe_scheduler (
  input  logic                          axi_clk,
  input  logic                          axi_resetn,

  input  logic [`STRIPE_ADDR_WIDTH-1:0] araddr,
  input  logic [`STRIPE_LENW_WIDTH-1:0] arlenw,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`STRIPE_DATA_WIDTH-1:0] rdata,
  output axi_lite_pkg::axi_resp_t       rresp,
  output logic                          rvalid,
  output logic                          rlast,
  input  logic                          rready,

  output logic                          beat_done,
  output logic                          burst_done,

  stripe_read_if.sched                  rd [`STRIPE_NUM_BANKS]
);
  import axi_lite_pkg::*;
  import stripe_pkg::*;

  localparam int NB     = `STRIPE_NUM_BANKS;
  localparam int ADDR_W = `STRIPE_ADDR_WIDTH;
  localparam int LENW_W = `STRIPE_LENW_WIDTH;
  localparam int IDX_W  = (NB > 1) ? $clog2(NB) : 1;

  localparam logic [LENW_W-1:0] NB_LENW  = LENW_W'(NB);
  localparam logic [IDX_W-1:0]  LAST_IDX = IDX_W'(NB - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_STREAM,
    S_DONE
  } state_t;

  state_t      state;
  state_t      next_state;
  stripe_cmd_t cmd;
  logic        accept;
  logic        final_beat;

  logic [IDX_W-1:0] bank_idx;

  // per-bank copies of the interface signals so the mux can use a variable index
  logic [NB-1:0]                         sched_arvalid;
  logic [NB-1:0]                         bank_arready;
  logic [NB-1:0][`STRIPE_DATA_WIDTH-1:0] bank_rdata;
  axi_resp_t [NB-1:0]                    bank_rresp;
  logic [NB-1:0]                         bank_rvalid;
  logic [NB-1:0]                         bank_rlast;

  assign arready = (state == S_IDLE);
  assign accept  = arvalid && arready;

  for (genvar i = 0; i < NB; i++) begin : gen_bank
    // each bank starts one word further on and serves every NB-th word
    assign rd[i].araddr  = cmd.addr + ADDR_W'(i);
    assign rd[i].arlenw  = cmd.lenw / NB_LENW;
    assign rd[i].arvalid = sched_arvalid[i];
    assign rd[i].rready  = (state == S_STREAM) && rready && (bank_idx == IDX_W'(i));

    assign bank_arready[i] = rd[i].arready;
    assign bank_rdata[i]   = rd[i].rdata;
    assign bank_rresp[i]   = rd[i].rresp;
    assign bank_rvalid[i]  = rd[i].rvalid;
    assign bank_rlast[i]   = rd[i].rlast;

    always_ff @(posedge axi_clk) begin
      if (!axi_resetn) begin
        sched_arvalid[i] <= 1'b0;
      end else if (accept) begin
        sched_arvalid[i] <= 1'b1;
      end else if (bank_arready[i]) begin
        sched_arvalid[i] <= 1'b0;
      end
    end
  end

  // the current source is whichever bank holds the next address
  assign rdata  = bank_rdata[bank_idx];
  assign rresp  = bank_rresp[bank_idx];
  assign rvalid = (state == S_STREAM) && bank_rvalid[bank_idx];
  assign rlast  = rvalid && bank_rlast[bank_idx] && (bank_idx == LAST_IDX);

  assign beat_done  = rvalid && rready;
  assign final_beat = beat_done && rlast;
  assign burst_done = (state == S_DONE);

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE: begin
        if (arvalid) begin
          next_state = S_START;
        end
      end
      S_START: begin
        next_state = S_STREAM;
      end
      S_STREAM: begin
        if (final_beat) begin
          next_state = S_DONE;
        end
      end
      default: begin
        next_state = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state    <= S_IDLE;
      bank_idx <= '0;
    end else begin
      state <= next_state;
      if (accept) begin
        bank_idx <= '0;
      end else if (beat_done) begin
        bank_idx <= (bank_idx == LAST_IDX) ? '0 : bank_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (accept) begin
      cmd.addr <= araddr;
      cmd.lenw <= arlenw;
    end
  end

endmodule

// ==== hdl/stripe_status_regs.sv ====
module stripe_status_regs (
  input  logic                               axi_clk,
  input  logic                               axi_resetn,

  input  logic                               beat_done,
  input  logic                               burst_done,
  input  axi_lite_pkg::axi_resp_t            beat_resp,

  input  stripe_pkg::stat_sel_t              stat_sel,
  input  logic                               stat_clear,
  output logic [stripe_pkg::STAT_WIDTH-1:0]  stat_data
);
  import axi_lite_pkg::*;
  import stripe_pkg::*;

  logic [STAT_WIDTH-1:0] burst_cnt;
  logic [STAT_WIDTH-1:0] error_cnt;

  // counters stick at all ones instead of wrapping back to zero
  function automatic logic [STAT_WIDTH-1:0] sat_inc(input logic [STAT_WIDTH-1:0] val);
    return (val == '1) ? val : val + 1'b1;
  endfunction

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn || stat_clear) begin
      burst_cnt <= '0;
      error_cnt <= '0;
    end else begin
      if (burst_done) begin
        burst_cnt <= sat_inc(burst_cnt);
      end
      // any response other than OKAY counts as an error beat
      if (beat_done && beat_resp != OKAY) begin
        error_cnt <= sat_inc(error_cnt);
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      stat_data <= '0;
    end else begin
      case (stat_sel)
        STAT_BURSTS: stat_data <= burst_cnt;
        default:     stat_data <= error_cnt;
      endcase
    end
  end

endmodule

// ==== hdl/stripe_read_top.sv ====
`include "stripe_settings.svh"

module stripe_read_top (
  input  logic                                                axi_clk,
  input  logic                                                axi_resetn,

  input  logic [`STRIPE_ADDR_WIDTH-1:0]                       araddr,
  input  logic [`STRIPE_LENW_WIDTH-1:0]                       arlenw,
  input  logic                                                arvalid,
  output logic                                                arready,
  output logic [`STRIPE_DATA_WIDTH-1:0]                       rdata,
  output axi_lite_pkg::axi_resp_t                             rresp,
  output logic                                                rvalid,
  output logic                                                rlast,
  input  logic                                                rready,

  output logic [`STRIPE_NUM_BANKS-1:0][`STRIPE_ADDR_WIDTH-1:0] bank_araddr,
  output logic [`STRIPE_NUM_BANKS-1:0]                         bank_arvalid,
  input  logic [`STRIPE_NUM_BANKS-1:0]                         bank_arready,
  input  logic [`STRIPE_NUM_BANKS-1:0][`STRIPE_DATA_WIDTH-1:0] bank_rdata,
  input  logic [`STRIPE_NUM_BANKS-1:0][                   1:0] bank_rresp,
  input  logic [`STRIPE_NUM_BANKS-1:0]                         bank_rvalid,
  output logic [`STRIPE_NUM_BANKS-1:0]                         bank_rready,

  input  stripe_pkg::stat_sel_t                               stat_sel,
  output logic [stripe_pkg::STAT_WIDTH-1:0]                   stat_data,
  input  logic                                                stat_clear
);

  logic beat_done;
  logic burst_done;

  stripe_read_if rd_if [`STRIPE_NUM_BANKS] ();

  stripe_scheduler stripe_scheduler_inst (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .araddr    (araddr),
    .arlenw    (arlenw),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .rready    (rready),
    .beat_done (beat_done),
    .burst_done(burst_done),
    .rd        (rd_if)
  );

  // the status block sees the same beats the caller does
  stripe_status_regs stripe_status_regs_inst (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .beat_done (beat_done),
    .burst_done(burst_done),
    .beat_resp (rresp),
    .stat_sel  (stat_sel),
    .stat_clear(stat_clear),
    .stat_data (stat_data)
  );

  for (genvar i = 0; i < `STRIPE_NUM_BANKS; i++) begin : gen_reader
    bank_burst_reader bank_burst_reader_inst (
      .axi_clk     (axi_clk),
      .axi_resetn  (axi_resetn),
      .rd          (rd_if[i]),
      .bank_araddr (bank_araddr[i]),
      .bank_arvalid(bank_arvalid[i]),
      .bank_arready(bank_arready[i]),
      .bank_rdata  (bank_rdata[i]),
      .bank_rresp  (bank_rresp[i]),
      .bank_rvalid (bank_rvalid[i]),
      .bank_rready (bank_rready[i])
    );
  end

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic axi_clk,
  output logic axi_resetn
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    axi_clk = 1'b0;
    forever #(PERIOD_NS / 2) axi_clk = ~axi_clk;
  end

  // release reset just after an edge, like every other driven input
  initial begin
    axi_resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge axi_clk);
    #1 axi_resetn = 1'b1;
  end

endmodule

// ==== tb/tb_bank_model.sv ====
`include "stripe_settings.svh"

module tb_bank_model #(
  parameter int BANK_IDX = 0,
  parameter int DEPTH    = 256,
  parameter int SEED     = 32'h7a1ff5c6
) (
  input  logic                                     axi_clk,
  input  logic [`STRIPE_ADDR_WIDTH-1:0]            araddr,
  input  logic                                     arvalid,
  output logic                                     arready,
  output logic [`STRIPE_DATA_WIDTH-1:0]            rdata,
  output logic [1:0]                               rresp,
  output logic                                     rvalid,
  input  logic                                     rready,
  output logic [DEPTH-1:0][`STRIPE_DATA_WIDTH-1:0] mem
);
  timeunit 1ns;
  timeprecision 1ps;
  import axi_lite_pkg::*;

  initial begin
    integer            seed;
    int                delay;
    int                local_idx;
    logic [`STRIPE_ADDR_WIDTH-1:0] addr;
    seed    = SEED + BANK_IDX;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = OKAY;
    for (int j = 0; j < DEPTH; j++) begin
      mem[j] = `STRIPE_DATA_WIDTH'($random(seed));
    end
    forever begin
      do begin
        @(posedge axi_clk);
      end while (!arvalid);
      #1;
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
        @(posedge axi_clk);
        #1;
      end
      // araddr stays put while arvalid waits for the handshake
      addr    = araddr;
      arready = 1'b1;
      @(posedge axi_clk);
      #1 arready = 1'b0;
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
        @(posedge axi_clk);
        #1;
      end
      // global address a lives at local word a divided by the bank count
      local_idx = int'(addr) / `STRIPE_NUM_BANKS;
      if (local_idx >= DEPTH) begin
        rdata = '0;
        rresp = SLVERR;
      end else begin
        rdata = mem[local_idx];
        rresp = OKAY;
      end
      rvalid = 1'b1;
      do begin
        @(posedge axi_clk);
      end while (!rready);
      #1 rvalid = 1'b0;
    end
  end

endmodule

// ==== tb/tb_stripe_read.sv ====
`include "stripe_settings.svh"

module tb_stripe_read;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_lite_pkg::*;
  import stripe_pkg::*;

  localparam int NB              = `STRIPE_NUM_BANKS;
  localparam int ADDR_W          = `STRIPE_ADDR_WIDTH;
  localparam int DATA_W          = `STRIPE_DATA_WIDTH;
  localparam int LENW_W          = `STRIPE_LENW_WIDTH;
  localparam int DEPTH           = 256;
  localparam int NUM_BURSTS      = 24;
  localparam int WATCHDOG_CYCLES = NUM_BURSTS * 200 + 20;

  logic                   axi_clk;
  logic                   axi_resetn;
  logic [ADDR_W-1:0]      araddr;
  logic [LENW_W-1:0]      arlenw;
  logic                   arvalid;
  logic                   arready;
  logic [DATA_W-1:0]      rdata;
  axi_resp_t              rresp;
  logic                   rvalid;
  logic                   rlast;
  logic                   rready;
  logic [NB-1:0][ADDR_W-1:0] bank_araddr;
  logic [NB-1:0]          bank_arvalid;
  wire  [NB-1:0]          bank_arready;
  wire  [NB-1:0][DATA_W-1:0] bank_rdata;
  wire  [NB-1:0][1:0]     bank_rresp;
  wire  [NB-1:0]          bank_rvalid;
  logic [NB-1:0]          bank_rready;
  stat_sel_t              stat_sel;
  logic [STAT_WIDTH-1:0]  stat_data;
  logic                   stat_clear;
  wire  [NB-1:0][DEPTH-1:0][DATA_W-1:0] bank_mem;

  integer seed = 32'h7a1ff5c6;
  int     error_beats;

  tb_clock_gen tb_clock_gen_inst (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn)
  );

  stripe_read_top stripe_read_top_inst (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .araddr      (araddr),
    .arlenw      (arlenw),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rlast       (rlast),
    .rready      (rready),
    .bank_araddr (bank_araddr),
    .bank_arvalid(bank_arvalid),
    .bank_arready(bank_arready),
    .bank_rdata  (bank_rdata),
    .bank_rresp  (bank_rresp),
    .bank_rvalid (bank_rvalid),
    .bank_rready (bank_rready),
    .stat_sel    (stat_sel),
    .stat_data   (stat_data),
    .stat_clear  (stat_clear)
  );

  for (genvar i = 0; i < NB; i++) begin : gen_bank
    tb_bank_model #(.BANK_IDX(i), .DEPTH(DEPTH)) tb_bank_model_inst (
      .axi_clk(axi_clk),
      .araddr (bank_araddr[i]),
      .arvalid(bank_arvalid[i]),
      .arready(bank_arready[i]),
      .rdata  (bank_rdata[i]),
      .rresp  (bank_rresp[i]),
      .rvalid (bank_rvalid[i]),
      .rready (bank_rready[i]),
      .mem    (bank_mem[i])
    );
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else
      stop_on_error($sformatf("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
                              $time, name, expected, actual));
  endtask

  // issue one command and take every beat, stalling rready at random
  task automatic run_burst(input logic [ADDR_W-1:0] addr, input logic [LENW_W-1:0] lenw);
    int          k;
    int          bank;
    int          local_idx;
    int          reads_issued [NB];
    logic        held;
    logic [DATA_W-1:0] held_data;
    axi_resp_t   held_resp;
    logic        held_last;
    logic [DATA_W-1:0] exp_data;
    axi_resp_t   exp_resp;
    araddr  = addr;
    arlenw  = lenw;
    arvalid = 1'b1;
    do begin
      @(posedge axi_clk);
    end while (!arready);
    #1 arvalid = 1'b0;
    k            = 0;
    held         = 1'b0;
    reads_issued = '{default: 0};
    while (k <= int'(lenw)) begin
      rready = ($random(seed) & 3) != 0;
      @(posedge axi_clk);
      check_value("arready", 32'd0, 32'(arready));
      // bank i reads addr + i first and then steps by the bank count
      for (int i = 0; i < NB; i++) begin
        if (bank_arvalid[i] && bank_arready[i]) begin
          check_value("bank_araddr", 32'(addr) + 32'(i + NB * reads_issued[i]),
                      32'(bank_araddr[i]));
          reads_issued[i]++;
        end
      end
      if (held) begin
        check_value("rvalid", 32'd1, 32'(rvalid));
        check_value("rdata", 32'(held_data), 32'(rdata));
        check_value("rresp", 32'(held_resp), 32'(rresp));
        check_value("rlast", 32'(held_last), 32'(rlast));
      end
      if (rvalid && rready) begin
        // global address addr + k sits in bank (addr + k) mod NB
        bank      = (int'(addr) + k) % NB;
        local_idx = (int'(addr) + k) / NB;
        if (local_idx >= DEPTH) begin
          exp_data = '0;
          exp_resp = SLVERR;
          error_beats++;
        end else begin
          exp_data = bank_mem[bank][local_idx];
          exp_resp = OKAY;
        end
        check_value("rdata", 32'(exp_data), 32'(rdata));
        check_value("rresp", 32'(exp_resp), 32'(rresp));
        check_value("rlast", 32'(k == int'(lenw)), 32'(rlast));
        k++;
        held = 1'b0;
      end else if (rvalid) begin
        held      = 1'b1;
        held_data = rdata;
        held_resp = rresp;
        held_last = rlast;
      end
      #1;
    end
    rready = 1'b0;
  endtask

  initial begin : stimulus
    logic [ADDR_W-1:0] addr;
    logic [LENW_W-1:0] lenw;
    int                beats_per_bank;
    araddr      = '0;
    arlenw      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    stat_sel    = STAT_BURSTS;
    stat_clear  = 1'b0;
    error_beats = 0;
    @(posedge axi_resetn);
    check_value("arready", 32'd1, 32'(arready));
    check_value("rvalid", 32'd0, 32'(rvalid));
    check_value("rlast", 32'd0, 32'(rlast));
    check_value("bank_arvalid", 32'd0, 32'(bank_arvalid));
    check_value("bank_rready", 32'd0, 32'(bank_rready));
    check_value("stat_data", 32'd0, 32'(stat_data));

    // start addresses stay aligned to the bank count and run past the bank depth
    for (int b = 0; b < NUM_BURSTS; b++) begin
      beats_per_bank = 1 + $unsigned($random(seed)) % 8;
      lenw = LENW_W'(NB * beats_per_bank - 1);
      addr = ADDR_W'(($unsigned($random(seed)) % 320) * NB);
      run_burst(addr, lenw);
    end
    while (!arready) begin
      @(posedge axi_clk);
      #1;
    end

    stat_sel = STAT_BURSTS;
    @(posedge axi_clk);
    #1 check_value("stat_data", 32'(NUM_BURSTS), 32'(stat_data));
    stat_sel = STAT_ERRORS;
    @(posedge axi_clk);
    #1 check_value("stat_data", 32'(error_beats), 32'(stat_data));
    stat_clear = 1'b1;
    @(posedge axi_clk);
    #1 stat_clear = 1'b0;
    @(posedge axi_clk);
    #1 check_value("stat_data", 32'd0, 32'(stat_data));
    stat_sel = STAT_BURSTS;
    @(posedge axi_clk);
    #1 check_value("stat_data", 32'd0, 32'(stat_data));

    $display("Test passed");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * 40);
    stop_on_error($sformatf("Error at %0t ns: the run hung and the watchdog expired", $time));
  end

endmodule

// ==== stripe_read.f ====
+incdir+hdl
hdl/axi_lite_pkg.sv
hdl/stripe_pkg.sv
hdl/stripe_read_if.sv
hdl/bank_burst_reader.sv
hdl/stripe_scheduler.sv
hdl/stripe_status_regs.sv
hdl/stripe_read_top.sv
tb/tb_clock_gen.sv
tb/tb_bank_model.sv
tb/tb_stripe_read.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  -f stripe_read.f \
  --top-module tb_stripe_read \
  -Mdir obj_dir \
  -o sim_stripe_read

./obj_dir/sim_stripe_read
